// ==== rtl/apu_consts.svh ====
`ifndef APU_CONSTS_SVH
`define APU_CONSTS_SVH

// Command queue entries, equal to the producer's starting input credits
`define APU_CMD_DEPTH 4

// Results the consumer can hold at once
`define APU_RES_CREDITS 4

// Operand and result width
`define APU_DW 32

`endif

// ==== rtl/apu_pkg.sv ====
`include "apu_consts.svh"

package apu_pkg;

	// Function codes as the coprocessor decodes them
	typedef enum logic [3:0] {
		FN_LOAD = 4'd0,
		FN_AND  = 4'd1,
		FN_OR   = 4'd2,
		FN_XOR  = 4'd3,
		FN_ADD  = 4'd4,
		FN_ADC  = 4'd5,
		FN_SUB  = 4'd6,
		FN_SBC  = 4'd7,
		FN_RR   = 4'd8,
		FN_RRC  = 4'd9,
		FN_SRA  = 4'd10,
		FN_SRZ  = 4'd11,
		FN_RL   = 4'd12,
		FN_RLC  = 4'd13,
		FN_MUL  = 4'd14,
		FN_MULS = 4'd15
	} apu_func_e;

	typedef enum logic [1:0] {
		SZ8  = 2'd0,
		SZ16 = 2'd1,
		SZ24 = 2'd2,
		SZ32 = 2'd3
	} apu_sz_e;

	typedef struct packed {
		logic [`APU_DW-1:0] src;
		logic [`APU_DW-1:0] arg;
		logic               c;    // Carry in
		apu_func_e          func;
		apu_sz_e            sz;
	} apu_cmd_t;

	// What a path hands to retire
	typedef struct packed {
		logic               valid;
		logic [`APU_DW-1:0] data;
		logic               fc;
		logic               fv;
		apu_sz_e            sz;
	} apu_unit_res_t;

	typedef struct packed {
		logic z;
		logic s;
		logic c;
		logic v;
	} apu_flags_t;

	typedef struct packed {
		logic [`APU_DW-1:0] data;
		apu_flags_t         flags;
	} apu_res_t;

endpackage

// ==== rtl/apu_cmd_fifo.sv ====
`timescale 1ns/1ps
`include "apu_consts.svh"

module apu_cmd_fifo #(
	parameter int DEPTH = `APU_CMD_DEPTH
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              push,
	input  apu_pkg::apu_cmd_t push_cmd,
	input  logic              pop,
	output logic              empty,
	output apu_pkg::apu_cmd_t head,
	output logic              credit
);

	localparam int AW = $clog2(DEPTH);
	localparam int CW = $clog2(DEPTH + 1);

	apu_pkg::apu_cmd_t mem [DEPTH];

	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;

	assign empty = (count == '0);
	assign head  = mem[rd_ptr];

	// Storage, the producer never overruns it thanks to credits
	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= push_cmd;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			credit <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			count  <= count + CW'(push) - CW'(pop);
			credit <= pop;    // One credit back per freed entry
		end
	end

endmodule

// ==== rtl/apu_alu.sv ====
`timescale 1ns/1ps
`include "apu_consts.svh"

module apu_alu (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   issue,
	input  apu_pkg::apu_cmd_t      cmd,
	output apu_pkg::apu_unit_res_t out
);

	localparam int W = `APU_DW;

	logic              s1_valid;
	apu_pkg::apu_cmd_t s1_cmd;

	logic [W-1:0] src_z;
	logic [W-1:0] arg_z;
	logic         top;
	logic         sc;
	logic [W:0]   sum;
	logic [W:0]   dif;
	logic [W:0]   as_r;
	logic         carry_sz;
	logic         ins_l;
	logic         ins_r;
	logic [W-1:0] r_rl;
	logic [W-1:0] r_rr;
	logic [W-1:0] res_d;
	logic         fc_d;

	logic             o_valid;
	logic [W-1:0]     o_data;
	logic             o_fc;
	apu_pkg::apu_sz_e o_sz;

	// Stage 1
	always_ff @(posedge clk) begin
		if (rst) begin
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= issue;
		end
	end

	always_ff @(posedge clk) begin
		if (issue) begin
			s1_cmd <= cmd;
		end
	end

	// Operands cut to the size, top bit of src at the size
	always_comb begin
		case (s1_cmd.sz)
			apu_pkg::SZ8: begin
				src_z = {24'h0, s1_cmd.src[7:0]};
				arg_z = {24'h0, s1_cmd.arg[7:0]};
				top   = s1_cmd.src[7];
			end
			apu_pkg::SZ16: begin
				src_z = {16'h0, s1_cmd.src[15:0]};
				arg_z = {16'h0, s1_cmd.arg[15:0]};
				top   = s1_cmd.src[15];
			end
			apu_pkg::SZ24: begin
				src_z = {8'h0, s1_cmd.src[23:0]};
				arg_z = {8'h0, s1_cmd.arg[23:0]};
				top   = s1_cmd.src[23];
			end
			apu_pkg::SZ32: begin
				src_z = s1_cmd.src;
				arg_z = s1_cmd.arg;
				top   = s1_cmd.src[31];
			end
		endcase
	end

	assign sc  = s1_cmd.c & s1_cmd.func[0];    // ADC and SBC only
	assign sum = {1'b0, src_z} + {1'b0, arg_z} + {{W{1'b0}}, sc};
	assign dif = {1'b0, src_z} - {1'b0, arg_z} - {{W{1'b0}}, sc};

	assign as_r = s1_cmd.func[1] ? dif : sum;

	// Carry sits just above the size
	always_comb begin
		case (s1_cmd.sz)
			apu_pkg::SZ8:  carry_sz = as_r[8];
			apu_pkg::SZ16: carry_sz = as_r[16];
			apu_pkg::SZ24: carry_sz = as_r[24];
			apu_pkg::SZ32: carry_sz = as_r[32];
		endcase
	end

	assign ins_l = s1_cmd.func[0] ? s1_cmd.c : top;
	assign ins_r = s1_cmd.func[1] ? (s1_cmd.func[0] ? 1'b0 : top) :
		(s1_cmd.func[0] ? s1_cmd.c : s1_cmd.src[0]);

	assign r_rl = {s1_cmd.src[W-2:0], ins_l};

	// Right shift over the whole word, bit 31 always takes the insert bit too
	always_comb begin
		r_rr = {ins_r, s1_cmd.src[W-1:1]};
		case (s1_cmd.sz)
			apu_pkg::SZ8:  r_rr[7]  = ins_r;
			apu_pkg::SZ16: r_rr[15] = ins_r;
			apu_pkg::SZ24: r_rr[23] = ins_r;
			apu_pkg::SZ32: r_rr[31] = ins_r;
		endcase
	end

	always_comb begin
		res_d = s1_cmd.src;
		fc_d  = 1'b0;
		case (s1_cmd.func)
			apu_pkg::FN_LOAD: res_d = s1_cmd.src;
			apu_pkg::FN_AND:  res_d = s1_cmd.src & s1_cmd.arg;
			apu_pkg::FN_OR:   res_d = s1_cmd.src | s1_cmd.arg;
			apu_pkg::FN_XOR:  res_d = s1_cmd.src ^ s1_cmd.arg;
			apu_pkg::FN_ADD, apu_pkg::FN_ADC,
			apu_pkg::FN_SUB, apu_pkg::FN_SBC: begin
				res_d = as_r[W-1:0];
				fc_d  = carry_sz;
			end
			apu_pkg::FN_RR, apu_pkg::FN_RRC,
			apu_pkg::FN_SRA, apu_pkg::FN_SRZ: begin
				res_d = r_rr;
				fc_d  = s1_cmd.src[0];
			end
			apu_pkg::FN_RL, apu_pkg::FN_RLC: begin
				res_d = r_rl;
				fc_d  = top;
			end
			default: res_d = '0;    // Multiplies never reach this path
		endcase
	end

	// Stage 2
	always_ff @(posedge clk) begin
		if (rst) begin
			o_valid <= 1'b0;
		end else begin
			o_valid <= s1_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (s1_valid) begin
			o_data <= res_d;
			o_fc   <= fc_d;
			o_sz   <= s1_cmd.sz;
		end
	end

	assign out = '{valid: o_valid, data: o_data, fc: o_fc, fv: 1'b0, sz: o_sz};

endmodule

// ==== rtl/apu_mul.sv ====
`timescale 1ns/1ps

module apu_mul (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   issue,
	input  apu_pkg::apu_cmd_t      cmd,
	output apu_pkg::apu_unit_res_t out
);

	logic        sg;
	logic        sgs8;
	logic        sga8;
	logic        sgs16;
	logic        sga16;
	logic [7:0]  src8;
	logic [7:0]  arg8;
	logic [15:0] src16;
	logic [15:0] arg16;
	logic [15:0] opa_d;
	logic [15:0] opb_d;
	logic        neg_d;

	logic             s1_valid;
	logic [15:0]      s1_a;
	logic [15:0]      s1_b;
	logic             s1_neg;
	apu_pkg::apu_sz_e s1_sz;
	logic [31:0]      prod;

	logic             o_valid;
	logic [31:0]      o_data;
	apu_pkg::apu_sz_e o_sz;

	assign sg    = (cmd.func == apu_pkg::FN_MULS);
	assign sgs8  = sg & cmd.src[7];
	assign sga8  = sg & cmd.arg[7];
	assign sgs16 = sg & cmd.src[15];
	assign sga16 = sg & cmd.arg[15];

	// Magnitudes of the low byte and halfword
	assign src8  = sgs8  ? 8'h0 - cmd.src[7:0]   : cmd.src[7:0];
	assign arg8  = sga8  ? 8'h0 - cmd.arg[7:0]   : cmd.arg[7:0];
	assign src16 = sgs16 ? 16'h0 - cmd.src[15:0] : cmd.src[15:0];
	assign arg16 = sga16 ? 16'h0 - cmd.arg[15:0] : cmd.arg[15:0];

	always_comb begin
		case (cmd.sz)
			apu_pkg::SZ8, apu_pkg::SZ16: begin    // 8 x 8
				opa_d = {8'h0, src8};
				opb_d = {8'h0, arg8};
				neg_d = sgs8 ^ sga8;
			end
			apu_pkg::SZ24: begin    // 16 x 8
				opa_d = src16;
				opb_d = {8'h0, arg8};
				neg_d = sgs16 ^ sga8;
			end
			apu_pkg::SZ32: begin    // 16 x 16
				opa_d = src16;
				opb_d = arg16;
				neg_d = sgs16 ^ sga16;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			s1_valid <= 1'b0;
			o_valid  <= 1'b0;
		end else begin
			s1_valid <= issue;
			o_valid  <= s1_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (issue) begin
			s1_a   <= opa_d;
			s1_b   <= opb_d;
			s1_neg <= neg_d;
			s1_sz  <= cmd.sz;
		end
	end

	assign prod = s1_a * s1_b;

	// Sign restored after the unsigned product
	always_ff @(posedge clk) begin
		if (s1_valid) begin
			o_data <= s1_neg ? 32'h0 - prod : prod;
			o_sz   <= s1_sz;
		end
	end

	// Carry comes from the sign in retire
	assign out = '{valid: o_valid, data: o_data, fc: 1'b0, fv: 1'b0, sz: o_sz};

endmodule

// ==== rtl/apu_retire.sv ====
`timescale 1ns/1ps
`include "apu_consts.svh"

module apu_retire (
	input  logic                   clk,
	input  logic                   rst,
	input  apu_pkg::apu_unit_res_t alu_res,
	input  apu_pkg::apu_unit_res_t mul_res,
	input  logic                   issue,
	input  logic                   res_credit,
	output logic                   issue_ok,
	output logic                   res_valid,
	output apu_pkg::apu_res_t      res
);

	localparam int CW = $clog2(`APU_RES_CREDITS + 1);

	apu_pkg::apu_unit_res_t sel;
	logic                   z_d;
	logic                   s_d;
	apu_pkg::apu_flags_t    flags_d;

	logic [CW-1:0]       credits;    // Unreserved output credits
	logic [`APU_DW-1:0]  r_data;
	apu_pkg::apu_flags_t r_flags;

	// Paths never finish in the same cycle
	assign sel = alu_res.valid ? alu_res : mul_res;

	always_comb begin
		case (sel.sz)
			apu_pkg::SZ8: begin
				z_d = (sel.data[7:0] == 8'h0);
				s_d = sel.data[7];
			end
			apu_pkg::SZ16: begin
				z_d = (sel.data[15:0] == 16'h0);
				s_d = sel.data[15];
			end
			apu_pkg::SZ24: begin
				z_d = (sel.data[23:0] == 24'h0);
				s_d = sel.data[23];
			end
			apu_pkg::SZ32: begin
				z_d = (sel.data == 32'h0);
				s_d = sel.data[31];
			end
		endcase
	end

	// Multiplies report C equal to S
	assign flags_d = '{
		z: z_d,
		s: s_d,
		c: alu_res.valid ? sel.fc : s_d,
		v: sel.fv
	};

	always_ff @(posedge clk) begin
		if (rst) begin
			res_valid <= 1'b0;
			credits   <= CW'(`APU_RES_CREDITS);
		end else begin
			res_valid <= sel.valid;
			credits   <= credits + CW'(res_credit) - CW'(issue);    // Reserve at issue
		end
	end

	always_ff @(posedge clk) begin
		if (sel.valid) begin
			r_data  <= sel.data;
			r_flags <= flags_d;
		end
	end

	assign issue_ok = (credits != '0);
	assign res      = '{data: r_data, flags: r_flags};

endmodule

// ==== rtl/apu_exec.sv ====
`timescale 1ns/1ps
`include "apu_consts.svh"

module apu_exec (
	input  logic              clk,
	input  logic              rst,
	input  logic              cmd_valid,
	input  apu_pkg::apu_cmd_t cmd,
	output logic              cmd_credit,
	output logic              res_valid,
	output apu_pkg::apu_res_t res,
	input  logic              res_credit
);

	logic                   empty;
	apu_pkg::apu_cmd_t      head;
	logic                   issue_ok;
	logic                   issue;
	logic                   is_mul;
	apu_pkg::apu_unit_res_t alu_res;
	apu_pkg::apu_unit_res_t mul_res;

	// One command per cycle, only with an output credit in hand
	assign issue  = !empty && issue_ok;
	assign is_mul = (head.func == apu_pkg::FN_MUL) || (head.func == apu_pkg::FN_MULS);

	apu_cmd_fifo #(
		.DEPTH(`APU_CMD_DEPTH)
	) u_fifo (
		.clk     (clk),
		.rst     (rst),
		.push    (cmd_valid),
		.push_cmd(cmd),
		.pop     (issue),
		.empty   (empty),
		.head    (head),
		.credit  (cmd_credit)
	);

	apu_alu u_alu (
		.clk  (clk),
		.rst  (rst),
		.issue(issue && !is_mul),
		.cmd  (head),
		.out  (alu_res)
	);

	apu_mul u_mul (
		.clk  (clk),
		.rst  (rst),
		.issue(issue && is_mul),
		.cmd  (head),
		.out  (mul_res)
	);

	apu_retire u_retire (
		.clk       (clk),
		.rst       (rst),
		.alu_res   (alu_res),
		.mul_res   (mul_res),
		.issue     (issue),
		.res_credit(res_credit),
		.issue_ok  (issue_ok),
		.res_valid (res_valid),
		.res       (res)
	);

endmodule

// ==== dv/apu_exec_chk.sv ====
`timescale 1ns/1ps
`include "apu_consts.svh"

module apu_exec_chk (
	input logic clk,
	input logic rst,
	input logic cmd_credit,
	input logic res_valid,
	input logic res_credit,
	input logic alu_valid,
	input logic mul_valid
);

	int avail;    // Output credits the unit still holds
	int fail_cnt = 0;    // Assertion failures so far

	always_ff @(posedge clk) begin
		if (rst) begin
			avail <= `APU_RES_CREDITS;
		end else begin
			avail <= avail - int'(res_valid) + int'(res_credit);
		end
	end

	a_res_credit: assert property (@(posedge clk) disable iff (rst) res_valid |-> avail > 0)
		else begin
			fail_cnt++;
			$error("res_valid raised with no output credit left");
		end

	// Both paths have the same latency, so one issue per cycle keeps them apart
	a_one_path: assert property (@(posedge clk) disable iff (rst) !(alu_valid && mul_valid))
		else begin
			fail_cnt++;
			$error("ALU and multiplier results valid in the same cycle");
		end

	a_credit_rst: assert property (@(posedge clk) rst |=> !cmd_credit)
		else begin
			fail_cnt++;
			$error("cmd_credit high during reset");
		end

endmodule

bind apu_exec apu_exec_chk u_chk (
	.clk       (clk),
	.rst       (rst),
	.cmd_credit(cmd_credit),
	.res_valid (res_valid),
	.res_credit(res_credit),
	.alu_valid (alu_res.valid),
	.mul_valid (mul_res.valid)
);

// ==== dv/apu_exec_tb.sv ====
`timescale 1ns/1ps
`include "apu_consts.svh"

module apu_exec_tb;

	logic              clk;
	logic              rst;
	logic              cmd_valid;
	apu_pkg::apu_cmd_t cmd;
	logic              cmd_credit;
	logic              res_valid;
	apu_pkg::apu_res_t res;
	logic              res_credit = 1'b0;

	apu_pkg::apu_res_t exp_q [$];    // Expected results in issue order
	apu_pkg::apu_res_t exp_r;

	int          in_credits;
	int          held;    // Results consumed, credit not yet returned
	int          received;
	int          checks;
	int          errors;
	int          chk0;
	int          err0;
	int          credit_pct = 100;
	logic        hold_credits = 1'b0;
	logic [31:0] stim_rs = 32'h21a9_1f0f;
	logic [31:0] cons_rs = ~32'h21a9_1f0f;
	logic [31:0] cr;

	logic [31:0] src_tab [4] = '{32'h0000_0000, 32'hffff_ffff, 32'h1234_ff03, 32'h8080_80fb};
	logic [31:0] arg_tab [4] = '{32'h0000_0000, 32'h0000_0001, 32'h0000_8007, 32'h7f7f_ff05};

	apu_exec DUT (
		.clk       (clk),
		.rst       (rst),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.cmd_credit(cmd_credit),
		.res_valid (res_valid),
		.res       (res),
		.res_credit(res_credit)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] lcg(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [31:0] stim_rand();
		stim_rs = lcg(stim_rs);
		return stim_rs;
	endfunction

	function automatic logic [31:0] cons_rand();
		cons_rs = lcg(cons_rs);
		return cons_rs;
	endfunction

	// Expected result straight from the function rules
	function automatic apu_pkg::apu_res_t apu_ref(input apu_pkg::apu_cmd_t c);
		int                n;
		logic [31:0]       m;
		logic [32:0]       t;
		logic [31:0]       d;
		logic              cf;
		logic              ins;
		logic              msb;
		logic              is_mul;
		longint            a;
		longint            b;
		apu_pkg::apu_res_t r;
		n      = 8 * (int'(c.sz) + 1);
		m      = (n == 32) ? 32'hffff_ffff : (32'h1 << n) - 32'h1;
		msb    = c.src[n-1];
		d      = c.src;
		cf     = 1'b0;
		is_mul = (c.func == apu_pkg::FN_MUL) || (c.func == apu_pkg::FN_MULS);
		case (c.func)
			apu_pkg::FN_AND: d = c.src & c.arg;
			apu_pkg::FN_OR:  d = c.src | c.arg;
			apu_pkg::FN_XOR: d = c.src ^ c.arg;
			apu_pkg::FN_ADD, apu_pkg::FN_ADC: begin
				t  = {1'b0, c.src & m} + {1'b0, c.arg & m};
				t  = t + ((c.func == apu_pkg::FN_ADC) ? 33'(c.c) : 33'd0);
				d  = t[31:0];
				cf = t[n];
			end
			apu_pkg::FN_SUB, apu_pkg::FN_SBC: begin
				t  = {1'b0, c.src & m} - {1'b0, c.arg & m};
				t  = t - ((c.func == apu_pkg::FN_SBC) ? 33'(c.c) : 33'd0);
				d  = t[31:0];
				cf = t[n];
			end
			apu_pkg::FN_RL, apu_pkg::FN_RLC: begin
				ins = (c.func == apu_pkg::FN_RLC) ? c.c : msb;
				d   = {c.src[30:0], ins};
				cf  = msb;
			end
			apu_pkg::FN_RR, apu_pkg::FN_RRC, apu_pkg::FN_SRA, apu_pkg::FN_SRZ: begin
				case (c.func)
					apu_pkg::FN_RR:  ins = c.src[0];
					apu_pkg::FN_RRC: ins = c.c;
					apu_pkg::FN_SRA: ins = msb;
					default:         ins = 1'b0;
				endcase
				d      = {ins, c.src[31:1]};
				d[n-1] = ins;    // Top of the size gets it as well
				cf     = c.src[0];
			end
			apu_pkg::FN_MUL, apu_pkg::FN_MULS: begin
				if (c.func == apu_pkg::FN_MULS) begin
					a = (c.sz >= apu_pkg::SZ24) ? longint'($signed(c.src[15:0])) :
						longint'($signed(c.src[7:0]));
					b = (c.sz == apu_pkg::SZ32) ? longint'($signed(c.arg[15:0])) :
						longint'($signed(c.arg[7:0]));
				end else begin
					a = (c.sz >= apu_pkg::SZ24) ? longint'(c.src[15:0]) : longint'(c.src[7:0]);
					b = (c.sz == apu_pkg::SZ32) ? longint'(c.arg[15:0]) : longint'(c.arg[7:0]);
				end
				d = 32'(a * b);
			end
			default: d = c.src;
		endcase
		r.data    = d;
		r.flags.z = ((d & m) == 32'h0);
		r.flags.s = d[n-1];
		r.flags.c = is_mul ? d[n-1] : cf;
		r.flags.v = 1'b0;
		return r;
	endfunction

	task automatic timeout_abort(input string what);
		$display("Timed out waiting for %s at %0t", what, $time);
		$display("Testbench failed");
		$finish;
	endtask

	// Input credits come back one per popped entry
	always @(posedge clk) begin
		if (rst) begin
			in_credits = `APU_CMD_DEPTH;
		end else if (cmd_credit) begin
			in_credits = in_credits + 1;
		end
	end

	// Compare each result, then maybe hand back a credit
	always @(negedge clk) begin
		if (!rst) begin
			if (res_valid) begin
				received++;
				held++;
				if (exp_q.size() == 0) begin
					errors++;
					$display("Result arrived at %0t with no command outstanding", $time);
				end else begin
					exp_r = exp_q.pop_front();
					checks++;
					if (res !== exp_r) begin
						errors++;
						$display("FAIL %0t: got %h flags %b, expected %h flags %b", $time,
							res.data, res.flags, exp_r.data, exp_r.flags);
					end
				end
			end
			cr = cons_rand();
			if (!hold_credits && held > 0 && int'(cr[31:16] % 100) < credit_pct) begin
				res_credit = 1'b1;
				held--;
			end else begin
				res_credit = 1'b0;
			end
		end
	end

	task automatic send_cmd(input apu_pkg::apu_cmd_t c);
		int guard;
		guard = 0;
		@(negedge clk);
		while (in_credits == 0) begin
			cmd_valid = 1'b0;
			@(negedge clk);
			guard++;
			if (guard > 2000) begin
				timeout_abort("an input credit");
			end
		end
		cmd_valid  = 1'b1;
		cmd        = c;
		in_credits = in_credits - 1;
		exp_q.push_back(apu_ref(c));
	endtask

	task automatic end_burst();
		@(negedge clk);
		cmd_valid = 1'b0;
	endtask

	task automatic wait_drain();
		int guard;
		guard = 0;
		while (exp_q.size() != 0 || held != 0) begin
			@(negedge clk);
			guard++;
			if (guard > 5000) begin
				timeout_abort("outstanding results");
			end
		end
	endtask

	task automatic begin_test();
		chk0 = checks;
		err0 = errors;
	endtask

	task automatic end_test(input int num, input string name);
		wait_drain();
		// Every popped entry has handed its input credit back by now
		checks++;
		if (in_credits != `APU_CMD_DEPTH) begin
			errors++;
			$display("FAIL %0t: %0d input credits after drain, expected %0d", $time,
				in_credits, `APU_CMD_DEPTH);
		end
		$display("test %0d %s: %0d checks, %0d errors", num, name, checks - chk0, errors - err0);
	endtask

	// Every size, function and carry-in over the operand table plus one random pair
	task automatic send_funcs(input int f_lo, input int f_hi);
		apu_pkg::apu_cmd_t c;
		for (int s = 0; s < 4; s++) begin
			for (int f = f_lo; f <= f_hi; f++) begin
				for (int ci = 0; ci < 2; ci++) begin
					for (int k = 0; k < 5; k++) begin
						c.func = apu_pkg::apu_func_e'(f);
						c.sz   = apu_pkg::apu_sz_e'(s);
						c.c    = ci[0];
						c.src  = (k < 4) ? src_tab[k] : stim_rand();
						c.arg  = (k < 4) ? arg_tab[k] : stim_rand();
						send_cmd(c);
					end
				end
			end
		end
		end_burst();
	endtask

	initial begin
		apu_pkg::apu_cmd_t c;
		logic [31:0]       r;
		int                rcv0;
		int                guard;
		rst       = 1'b1;
		cmd_valid = 1'b0;
		cmd       = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		begin_test();
		send_funcs(0, 3);
		end_test(1, "load and logic");

		begin_test();
		send_funcs(4, 7);
		end_test(2, "add and subtract");

		begin_test();
		send_funcs(8, 13);
		end_test(3, "rotate and shift");

		begin_test();
		send_funcs(14, 15);
		end_test(4, "multiply");

		// Withhold output credits until the queue backs up
		begin_test();
		hold_credits = 1'b1;
		rcv0         = received;
		for (int i = 0; i < `APU_RES_CREDITS + `APU_CMD_DEPTH; i++) begin
			r     = stim_rand();
			c.func = apu_pkg::apu_func_e'(r[3:0]);
			c.sz   = apu_pkg::apu_sz_e'(r[5:4]);
			c.c    = r[6];
			c.src  = stim_rand();
			c.arg  = stim_rand();
			send_cmd(c);
		end
		end_burst();
		guard = 0;
		while (received - rcv0 < `APU_RES_CREDITS) begin
			@(negedge clk);
			guard++;
			if (guard > 200) begin
				timeout_abort("the first results under back-pressure");
			end
		end
		repeat (20) @(negedge clk);    // Give extra results a chance to leak out
		checks++;
		if (received - rcv0 != `APU_RES_CREDITS) begin
			errors++;
			$display("FAIL %0t: %0d results without credit return, expected %0d", $time,
				received - rcv0, `APU_RES_CREDITS);
		end
		hold_credits = 1'b0;
		end_test(5, "back-pressure");

		begin_test();
		credit_pct = 35;
		for (int i = 0; i < 300; i++) begin
			r      = stim_rand();
			c.func = apu_pkg::apu_func_e'(r[3:0]);
			c.sz   = apu_pkg::apu_sz_e'(r[5:4]);
			c.c    = r[6];
			c.src  = stim_rand();
			c.arg  = stim_rand();
			send_cmd(c);
			if (r[15:12] == 4'h0) begin
				end_burst();    // Occasional idle cycle
			end
		end
		end_burst();
		end_test(6, "random mix");

		errors = errors + DUT.u_chk.fail_cnt;    // Bound assertion failures
		$display("%0d checks, %0d errors, %0d results", checks, errors, received);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+rtl
rtl/apu_pkg.sv
rtl/apu_cmd_fifo.sv
rtl/apu_alu.sv
rtl/apu_mul.sv
rtl/apu_retire.sv
rtl/apu_exec.sv
dv/apu_exec_chk.sv
dv/apu_exec_tb.sv

// ==== Bender.yml ====
package:
  name: apu_exec

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/apu_pkg.sv
      - rtl/apu_cmd_fifo.sv
      - rtl/apu_alu.sv
      - rtl/apu_mul.sv
      - rtl/apu_retire.sv
      - rtl/apu_exec.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - dv/apu_exec_chk.sv
      - dv/apu_exec_tb.sv
